/* all.f */
+incdir+verification
source/kbd_pkg.sv
source/ps2_receiver.sv
source/keycode_hold.sv
source/ppi_ports.sv
source/xt_keyboard_top.sv
verification/tb_xt_keyboard.sv

/* run_sim.sh */
#!/bin/sh
# compile with Verilator, run, and decide pass or fail from the log
rm -f sim.log
verilator --binary --timing --assert -f all.f --top-module tb_xt_keyboard -o sim_tb \
    && ./obj_dir/sim_tb 2>&1 | tee sim.log

grep -qx "PASS: all tests" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* source/kbd_pkg.sv */
// shared types and constants for the XT keyboard path
// the receiver, the hold stage, the port block and the testbench refer to
// these by scoped names
package kbd_pkg;

    // data byte on the I/O bus, also used for scan codes and port values
    typedef logic [7:0] byte_t;

    // I/O address bits 9..0 as seen by the decoder
    typedef logic [9:0] io_addr_t;

    // 32-byte I/O slot of the port block, 0x060
    localparam logic [2:0] ppi_block = 3'd3;

    // port slot within the block, from address bits 1..0
    typedef enum logic [1:0] {
        port_a    = 2'd0,
        port_b    = 2'd1,
        port_c    = 2'd2,
        port_ctrl = 2'd3
    } port_sel_e;

    // PS/2 frame receiver states
    typedef enum logic [1:0] {
        rx_idle   = 2'd0,
        rx_data   = 2'd1,
        rx_parity = 2'd2,
        rx_stop   = 2'd3
    } rx_state_e;

    // port B control bits
    localparam int portb_clear_bit  = 7;
    localparam int portb_enable_bit = 6;

    // data bits carried by one PS/2 frame
    localparam int frame_data_bits = 8;

endpackage

/* source/keycode_hold.sv */
// one-entry keycode buffer between the PS/2 receiver and port A.
// While a code is held the keyboard interrupt is up and the PS/2 clock
// is pulled low to stop the device from sending more.
`timescale 1ns/1ps

module keycode_hold (
    input  logic           clock,
    input  logic           reset,
    input  logic           scan_valid_i,
    input  kbd_pkg::byte_t scan_code_i,
    input  logic           clear_keycode_i,
    input  logic           kbd_enable_i,
    output kbd_pkg::byte_t keycode_o,
    output logic           key_held_o,
    output logic           ps2_clock_out_o
);

    logic           full_q;
    kbd_pkg::byte_t keycode_q;

    // port A must read zero while empty, so the code register is cleared too
    always_ff @(posedge clock) begin
        if (reset) begin
            full_q    <= 1'b0;
            keycode_q <= '0;
        end else if (clear_keycode_i) begin
            full_q    <= 1'b0;
            keycode_q <= '0;
        end else if (scan_valid_i && !full_q) begin
            full_q    <= 1'b1;
            keycode_q <= scan_code_i;
        end
    end

    assign keycode_o  = keycode_q;
    assign key_held_o = full_q;

    // inhibit when full or when the keyboard is disabled
    assign ps2_clock_out_o = ~(full_q | ~kbd_enable_i);

    // a held code stays until port B clears it, later codes are dropped
    a_hold_until_clear: assert property (
        @(posedge clock) disable iff (reset)
        key_held_o && !clear_keycode_i |=> key_held_o && $stable(keycode_o)
    );

endmodule

/* source/ppi_ports.sv */
// 8255-style port block on the I/O bus at 0x060-0x07F.
// Port A returns the held keycode, port B is a read/write control register
// and port C reads external inputs. Port directions are fixed.
`timescale 1ns/1ps

module ppi_ports (
    input  logic              clock,
    input  logic              reset,
    input  kbd_pkg::io_addr_t io_address_i,
    input  kbd_pkg::byte_t    io_data_i,
    input  logic              io_read_n_i,
    input  logic              io_write_n_i,
    input  logic              address_enable_n_i,
    input  kbd_pkg::byte_t    keycode_i,
    input  kbd_pkg::byte_t    port_c_i,
    output kbd_pkg::byte_t    data_bus_out_o,
    output kbd_pkg::byte_t    port_b_o,
    output logic              data_bus_out_from_chipset_o,
    output logic              clear_keycode_o,
    output logic              kbd_enable_o
);

    logic               block_sel;
    kbd_pkg::port_sel_e port_sel;
    logic               port_b_write;
    kbd_pkg::byte_t     port_b_q;
    kbd_pkg::byte_t     port_read;

    // block select, same slot scheme as the chipset decoder
    assign block_sel = ~address_enable_n_i
                     & (io_address_i[9:8] == 2'b00)
                     & (io_address_i[7:5] == kbd_pkg::ppi_block);

    assign port_sel = kbd_pkg::port_sel_e'(io_address_i[1:0]);

    // only port B takes writes
    assign port_b_write = block_sel & ~io_write_n_i & (port_sel == kbd_pkg::port_b);

    always_ff @(posedge clock) begin
        if (reset) begin
            port_b_q <= '0;
        end else if (port_b_write) begin
            port_b_q <= io_data_i;
        end
    end

    assign port_b_o        = port_b_q;
    assign clear_keycode_o = port_b_q[kbd_pkg::portb_clear_bit];
    assign kbd_enable_o    = port_b_q[kbd_pkg::portb_enable_bit];

    // selected port value
    always_comb begin
        unique case (port_sel)
            kbd_pkg::port_a: port_read = keycode_i;
            kbd_pkg::port_b: port_read = port_b_q;
            kbd_pkg::port_c: port_read = port_c_i;
            default:         port_read = '0;
        endcase
    end

    // read mux toward the CPU data bus
    // the bus is wired-or with other chipset sources upstream
    always_comb begin
        if (block_sel && !io_read_n_i) begin
            data_bus_out_from_chipset_o = 1'b1;
            data_bus_out_o              = port_read;
        end else begin
            data_bus_out_from_chipset_o = 1'b0;
            data_bus_out_o              = '0;
        end
    end

    // port B moves only on a decoded port B write
    a_port_b_stable: assert property (
        @(posedge clock) disable iff (reset)
        !port_b_write |=> $stable(port_b_o)
    );

endmodule

/* source/ps2_receiver.sv */
// PS/2 keyboard receiver; synchronizes the device clock and data lines and
// deframes start, data, odd parity and stop bits into one scan code.
// A good frame gives a one-cycle scan_valid_o pulse with the code.
`timescale 1ns/1ps

module ps2_receiver #(
    parameter logic [15:0] ps2_over_time = 16'd1000
) (
    input  logic           clock,
    input  logic           reset,
    input  logic           ps2_clock_i,
    input  logic           ps2_data_i,
    output logic           scan_valid_o,
    output kbd_pkg::byte_t scan_code_o
);

    localparam int count_w = $clog2(kbd_pkg::frame_data_bits);
    localparam logic [count_w-1:0] last_bit = count_w'(kbd_pkg::frame_data_bits - 1);

    logic               clock_meta;
    logic               clock_sync;
    logic               clock_prev;
    logic               data_meta;
    logic               data_sync;
    logic               data_bit;
    logic               fall_q;
    kbd_pkg::rx_state_e state_q;
    logic [count_w-1:0] bit_count_q;
    kbd_pkg::byte_t     shift_q;
    logic               parity_ok_q;
    logic [15:0]        idle_count_q;
    logic               timeout;

    // two-flop synchronizers, then a registered falling edge
    // data_bit is delayed one more stage so it lines up with fall_q
    always_ff @(posedge clock) begin
        if (reset) begin
            clock_meta <= 1'b1;
            clock_sync <= 1'b1;
            clock_prev <= 1'b1;
            data_meta  <= 1'b1;
            data_sync  <= 1'b1;
            data_bit   <= 1'b1;
            fall_q     <= 1'b0;
        end else begin
            clock_meta <= ps2_clock_i;
            clock_sync <= clock_meta;
            clock_prev <= clock_sync;
            data_meta  <= ps2_data_i;
            data_sync  <= data_meta;
            data_bit   <= data_sync;
            fall_q     <= clock_prev & ~clock_sync;
        end
    end

    // cycles since the last edge while a frame is open
    always_ff @(posedge clock) begin
        if (reset || fall_q || state_q == kbd_pkg::rx_idle) begin
            idle_count_q <= '0;
        end else begin
            idle_count_q <= idle_count_q + 16'd1;
        end
    end

    assign timeout = (state_q != kbd_pkg::rx_idle) && (idle_count_q >= ps2_over_time - 16'd1);

    // frame FSM, one step per falling edge
    always_ff @(posedge clock) begin
        if (reset) begin
            state_q      <= kbd_pkg::rx_idle;
            bit_count_q  <= '0;
            parity_ok_q  <= 1'b0;
            scan_valid_o <= 1'b0;
        end else begin
            scan_valid_o <= 1'b0;
            if (timeout) begin
                // partial frame abandoned
                state_q <= kbd_pkg::rx_idle;
            end else if (fall_q) begin
                unique case (state_q)
                    kbd_pkg::rx_idle: begin
                        // start bit must be low
                        if (!data_bit) begin
                            state_q     <= kbd_pkg::rx_data;
                            bit_count_q <= '0;
                        end
                    end
                    kbd_pkg::rx_data: begin
                        bit_count_q <= bit_count_q + 1'b1;
                        if (bit_count_q == last_bit) begin
                            state_q <= kbd_pkg::rx_parity;
                        end
                    end
                    kbd_pkg::rx_parity: begin
                        // odd parity over data plus parity bit
                        parity_ok_q <= ^{shift_q, data_bit};
                        state_q     <= kbd_pkg::rx_stop;
                    end
                    kbd_pkg::rx_stop: begin
                        scan_valid_o <= data_bit & parity_ok_q;
                        state_q      <= kbd_pkg::rx_idle;
                    end
                    default: state_q <= kbd_pkg::rx_idle;
                endcase
            end
        end
    end

    // data arrives LSB first
    always_ff @(posedge clock) begin
        if (fall_q && state_q == kbd_pkg::rx_data) begin
            shift_q <= {data_bit, shift_q[7:1]};
        end
    end

    always_ff @(posedge clock) begin
        if (fall_q && state_q == kbd_pkg::rx_stop) begin
            scan_code_o <= shift_q;
        end
    end

    // a new frame needs at least eleven edges, so pulses never touch
    a_single_pulse: assert property (
        @(posedge clock) disable iff (reset)
        scan_valid_o |=> !scan_valid_o
    );

endmodule

/* source/xt_keyboard_top.sv */
// XT keyboard path: PS/2 receiver, keycode hold stage and 8255-style ports.
// Connect the I/O bus and the PS/2 lines; ps2_clock_out_o low inhibits
// the keyboard.
`timescale 1ns/1ps

module xt_keyboard_top #(
    parameter logic [15:0] ps2_over_time = 16'd1000
) (
    input  logic              clock,
    input  logic              reset,
    // I/O bus
    input  kbd_pkg::io_addr_t io_address_i,
    input  kbd_pkg::byte_t    io_data_i,
    input  logic              io_read_n_i,
    input  logic              io_write_n_i,
    input  logic              address_enable_n_i,
    output kbd_pkg::byte_t    data_bus_out_o,
    output logic              data_bus_out_from_chipset_o,
    // keyboard
    input  logic              ps2_clock_i,
    input  logic              ps2_data_i,
    output logic              ps2_clock_out_o,
    // ports and interrupt
    input  kbd_pkg::byte_t    port_c_i,
    output kbd_pkg::byte_t    port_b_o,
    output logic              keyboard_irq_o
);

    logic           scan_valid;
    kbd_pkg::byte_t scan_code;
    kbd_pkg::byte_t keycode;
    logic           clear_keycode;
    logic           kbd_enable;

    ps2_receiver #(
        .ps2_over_time (ps2_over_time)
    ) u_ps2_receiver (
        .clock        (clock),
        .reset        (reset),
        .ps2_clock_i  (ps2_clock_i),
        .ps2_data_i   (ps2_data_i),
        .scan_valid_o (scan_valid),
        .scan_code_o  (scan_code)
    );

    // held code doubles as the keyboard interrupt
    keycode_hold u_keycode_hold (
        .clock           (clock),
        .reset           (reset),
        .scan_valid_i    (scan_valid),
        .scan_code_i     (scan_code),
        .clear_keycode_i (clear_keycode),
        .kbd_enable_i    (kbd_enable),
        .keycode_o       (keycode),
        .key_held_o      (keyboard_irq_o),
        .ps2_clock_out_o (ps2_clock_out_o)
    );

    ppi_ports u_ppi_ports (
        .clock                       (clock),
        .reset                       (reset),
        .io_address_i                (io_address_i),
        .io_data_i                   (io_data_i),
        .io_read_n_i                 (io_read_n_i),
        .io_write_n_i                (io_write_n_i),
        .address_enable_n_i          (address_enable_n_i),
        .keycode_i                   (keycode),
        .port_c_i                    (port_c_i),
        .data_bus_out_o              (data_bus_out_o),
        .port_b_o                    (port_b_o),
        .data_bus_out_from_chipset_o (data_bus_out_from_chipset_o),
        .clear_keycode_o             (clear_keycode),
        .kbd_enable_o                (kbd_enable)
    );

endmodule

/* verification/tb_ps2_tasks.svh */
// I/O bus cycles and a PS/2 keyboard model for the keyboard testbench
// included inside the testbench module; tasks drive 1 ns after the rising edge
`ifndef TB_PS2_TASKS_SVH
`define TB_PS2_TASKS_SVH

task automatic step_cycles(input int n);
    repeat (n) @(posedge clock);
    #1;
endtask

// port address with random mirror bits 4..2
function automatic kbd_pkg::io_addr_t port_addr(input kbd_pkg::port_sel_e sel);
    kbd_pkg::byte_t r;
    r = rand_byte();
    return {2'b00, kbd_pkg::ppi_block, r[2:0], sel};
endfunction

task automatic bus_write(input kbd_pkg::io_addr_t addr, input kbd_pkg::byte_t data);
    step_cycles(1);
    io_address_i       = addr;
    io_data_i          = data;
    address_enable_n_i = 1'b0;
    io_write_n_i       = 1'b0;
    step_cycles(1);
    io_write_n_i       = 1'b1;
    address_enable_n_i = 1'b1;
endtask

// read data is combinational, sampled at the falling edge
task automatic bus_read(input kbd_pkg::io_addr_t addr, input logic aen_n,
                        output kbd_pkg::byte_t data, output logic flag);
    step_cycles(1);
    io_address_i       = addr;
    address_enable_n_i = aen_n;
    io_read_n_i        = 1'b0;
    @(negedge clock);
    data = data_bus_out_o;
    flag = data_bus_out_from_chipset_o;
    step_cycles(1);
    io_read_n_i        = 1'b1;
    address_enable_n_i = 1'b1;
endtask

task automatic read_check(input kbd_pkg::port_sel_e sel, input kbd_pkg::byte_t expected,
                          input string what);
    kbd_pkg::byte_t data;
    logic           flag;
    bus_read(port_addr(sel), 1'b0, data, flag);
    check_value({what, " chipset flag"}, 8'(flag), 8'd1);
    check_value(what, data, expected);
endtask

task automatic wait_clock_released(input int max_cycles);
    int n;
    n = 0;
    @(negedge clock);
    while (ps2_clock_out_o !== 1'b1 && n < max_cycles) begin
        @(negedge clock);
        n++;
    end
    if (ps2_clock_out_o !== 1'b1) begin
        report_timeout("DUT never released the PS/2 clock");
    end
    step_cycles(1);
endtask

task automatic wait_irq(input int max_cycles);
    int n;
    n = 0;
    @(negedge clock);
    while (keyboard_irq_o !== 1'b1 && n < max_cycles) begin
        @(negedge clock);
        n++;
    end
    if (keyboard_irq_o !== 1'b1) begin
        report_timeout("keyboard interrupt did not rise after the stop bit");
    end
endtask

task automatic expect_quiet(input int n);
    for (int i = 0; i < n; i++) begin
        @(negedge clock);
        check_value("keyboard_irq_o after bad frame", 8'(keyboard_irq_o), 8'd0);
    end
endtask

// start, 8 data bits LSB first, odd parity, stop; 20 cycles per bit
// returns with the clock low after the last bit sent
task automatic send_frame(input kbd_pkg::byte_t code, input logic bad_parity,
                          input logic bad_stop, input int n_bits);
    logic [10:0] bits;
    bits = {~bad_stop, (~^code) ^ bad_parity, code, 1'b0};
    wait_clock_released(200);
    for (int i = 0; i < n_bits; i++) begin
        step_cycles(5);
        ps2_data_i = bits[i];
        step_cycles(5);
        ps2_clock_i = 1'b0;
        if (i != n_bits - 1) begin
            step_cycles(10);
            ps2_clock_i = 1'b1;
        end
    end
endtask

task automatic finish_frame();
    step_cycles(10);
    ps2_clock_i = 1'b1;
    step_cycles(5);
    ps2_data_i = 1'b1;
    step_cycles(20);
endtask

`endif

/* verification/tb_xt_keyboard.sv */
// testbench for the XT keyboard path
// drives the I/O bus and a PS/2 keyboard model, checks ports, interrupt and
// inhibit against a model of port B and the held code
`timescale 1ns/1ps

module tb_xt_keyboard;

    logic              clock;
    logic              reset;
    kbd_pkg::io_addr_t io_address_i;
    kbd_pkg::byte_t    io_data_i;
    logic              io_read_n_i;
    logic              io_write_n_i;
    logic              address_enable_n_i;
    kbd_pkg::byte_t    data_bus_out_o;
    logic              data_bus_out_from_chipset_o;
    logic              ps2_clock_i;
    logic              ps2_data_i;
    logic              ps2_clock_out_o;
    kbd_pkg::byte_t    port_c_i;
    kbd_pkg::byte_t    port_b_o;
    logic              keyboard_irq_o;

    int             seed;
    int             error_count;
    // reference model state
    kbd_pkg::byte_t model_port_b;
    kbd_pkg::byte_t model_code;
    logic           model_held;

    xt_keyboard_top i_xt_keyboard_top (
        .clock                       (clock),
        .reset                       (reset),
        .io_address_i                (io_address_i),
        .io_data_i                   (io_data_i),
        .io_read_n_i                 (io_read_n_i),
        .io_write_n_i                (io_write_n_i),
        .address_enable_n_i          (address_enable_n_i),
        .data_bus_out_o              (data_bus_out_o),
        .data_bus_out_from_chipset_o (data_bus_out_from_chipset_o),
        .ps2_clock_i                 (ps2_clock_i),
        .ps2_data_i                  (ps2_data_i),
        .ps2_clock_out_o             (ps2_clock_out_o),
        .port_c_i                    (port_c_i),
        .port_b_o                    (port_b_o),
        .keyboard_irq_o              (keyboard_irq_o)
    );

    initial clock = 1'b0;
    always #2 clock = ~clock;

    task automatic check_value(input string what, input kbd_pkg::byte_t actual,
                               input kbd_pkg::byte_t expected);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %0t: %s, got %h expected %h", $time, what, actual, expected);
            $display("FAIL: see errors above");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        error_count++;
        $display("timeout: %s", what);
        $display("FAIL: see errors above");
        $fatal(1, "stopped on timeout");
    endtask

    function automatic kbd_pkg::byte_t rand_byte();
        int r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // model of port B and the one-entry hold stage
    task automatic model_write_port_b(input kbd_pkg::byte_t data);
        model_port_b = data;
        if (data[kbd_pkg::portb_clear_bit]) begin
            model_code = '0;
            model_held = 1'b0;
        end
    endtask

    task automatic model_frame(input kbd_pkg::byte_t code);
        if (!model_held && !model_port_b[kbd_pkg::portb_clear_bit]) begin
            model_code = code;
            model_held = 1'b1;
        end
    endtask

    `include "tb_ps2_tasks.svh"

    // wait one cycle so register updates settle, then compare at the falling edge
    task automatic check_outputs();
        logic inhibit_n;
        @(posedge clock);
        @(negedge clock);
        inhibit_n = model_port_b[kbd_pkg::portb_enable_bit] & ~model_held;
        check_value("port_b_o", port_b_o, model_port_b);
        check_value("keyboard_irq_o", 8'(keyboard_irq_o), 8'(model_held));
        check_value("ps2_clock_out_o", 8'(ps2_clock_out_o), 8'(inhibit_n));
    endtask

    task automatic write_port_b(input kbd_pkg::byte_t data);
        bus_write(port_addr(kbd_pkg::port_b), data);
        model_write_port_b(data);
        check_outputs();
    endtask

    // full good frame, interrupt within 8 cycles, code back on port A
    task automatic receive_code(input kbd_pkg::byte_t code);
        send_frame(code, 1'b0, 1'b0, 11);
        model_frame(code);
        wait_irq(8);
        finish_frame();
        check_outputs();
        read_check(kbd_pkg::port_a, model_code, "port A keycode");
    endtask

    initial begin
        kbd_pkg::byte_t    data;
        kbd_pkg::io_addr_t addr;
        logic              flag;
        seed               = 16928;
        error_count        = 0;
        reset              = 1'b1;
        io_address_i       = '0;
        io_data_i          = '0;
        io_read_n_i        = 1'b1;
        io_write_n_i       = 1'b1;
        address_enable_n_i = 1'b1;
        ps2_clock_i        = 1'b1;
        ps2_data_i         = 1'b1;
        port_c_i           = '0;
        model_port_b       = '0;
        model_code         = '0;
        model_held         = 1'b0;
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;

        // reset state
        check_outputs();
        check_value("chipset flag after reset", 8'(data_bus_out_from_chipset_o), 8'd0);
        read_check(kbd_pkg::port_b, 8'h00, "port B after reset");

        // port B read back, port C and the control slot
        for (int i = 0; i < 8; i++) begin
            write_port_b(rand_byte() & 8'h3f);
            read_check(kbd_pkg::port_b, model_port_b, "port B read back");
        end
        port_c_i = rand_byte();
        read_check(kbd_pkg::port_c, port_c_i, "port C input");
        read_check(kbd_pkg::port_ctrl, 8'h00, "control slot");

        // no decode with address enable high or outside the block
        bus_read(port_addr(kbd_pkg::port_b), 1'b1, data, flag);
        check_value("flag with AEN high", 8'(flag), 8'd0);
        check_value("data with AEN high", data, 8'h00);
        for (int i = 0; i < 6; i++) begin
            data = rand_byte();
            addr = {data[1:0], rand_byte()};
            // even reads alias the block slot through bits 9..8
            if (i % 2 == 0) begin
                addr[7:5] = kbd_pkg::ppi_block;
            end
            if (addr[9:5] == {2'b00, kbd_pkg::ppi_block}) begin
                addr[9] = 1'b1;
            end
            bus_read(addr, 1'b0, data, flag);
            check_value("flag outside block", 8'(flag), 8'd0);
            check_value("data outside block", data, 8'h00);
        end

        // writes to port A and port C leave port B alone
        bus_write(port_addr(kbd_pkg::port_a), rand_byte());
        bus_write(port_addr(kbd_pkg::port_c), rand_byte());
        check_outputs();

        // enable the keyboard and receive a code
        write_port_b(8'h40);
        receive_code(rand_byte());

        // clear pulse, then a second code
        write_port_b(8'hc0);
        read_check(kbd_pkg::port_a, 8'h00, "port A after clear");
        write_port_b(8'h40);
        receive_code(rand_byte());
        write_port_b(8'hc0);
        write_port_b(8'h40);

        // bad parity and bad stop bit are dropped
        send_frame(rand_byte(), 1'b1, 1'b0, 11);
        expect_quiet(40);
        finish_frame();
        send_frame(rand_byte(), 1'b0, 1'b1, 11);
        expect_quiet(40);
        finish_frame();
        check_outputs();
        receive_code(rand_byte());
        write_port_b(8'hc0);
        write_port_b(8'h40);

        // broken frame abandoned after the idle timeout
        send_frame(rand_byte(), 1'b0, 1'b0, 5);
        finish_frame();
        step_cycles(1100);
        check_outputs();
        receive_code(rand_byte());

        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
